/* Makefile */
TOP = ramctrl_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f ramctrl.f \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

/* ram_bank.sv */
//##########################################################
// ram bank: 16-bit synchronous RAM with a fixed access
// delay and a level acknowledge held while strobed
//##########################################################

`timescale 1ns/1ps

module ram_bank #(
  parameter int LATENCY = 1
) (
  input  logic                           clk,
  input  logic                           rst,
  input  ramctrl_pkg::bank_cmd_t         cmd,
  input  logic [ramctrl_pkg::HALF_W-1:0] wdata,
  output logic [ramctrl_pkg::HALF_W-1:0] rdata,
  output logic                           ack
);

  import ramctrl_pkg::*;

  localparam int CNT_W = $clog2(LATENCY + 1);

  logic [HALF_W-1:0] mem [BANK_DEPTH];
  logic [CNT_W-1:0]  cnt;
  logic              access;

  // delay counter, saturates at LATENCY while strobed
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (!cmd.stb) begin
      cnt <= '0;
    end else if (cnt != CNT_W'(LATENCY)) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign ack = (cnt == CNT_W'(LATENCY));

  // the edge on which ack rises
  assign access = cmd.stb && (cnt == CNT_W'(LATENCY - 1));

  // one access per strobe period
  always_ff @(posedge clk) begin
    if (access) begin
      if (cmd.we) begin
        mem[cmd.addr] <= wdata;
      end else begin
        rdata <= mem[cmd.addr];
      end
    end
  end

endmodule

/* ram_req_decode.sv */
//##########################################################
// request decoder: range check, operation decode and
// latching of an accepted requester strobe
//##########################################################

`timescale 1ns/1ps

module ram_req_decode (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           data_stb,
  input  logic                           data_we,
  input  logic [ramctrl_pkg::ADDR_W-1:0] data_addr,
  input  logic [ramctrl_pkg::DATA_W-1:0] data_din,
  input  logic                           idle,
  output ramctrl_pkg::ram_req_t          req,
  output logic                           req_valid
);

  import ramctrl_pkg::*;

  logic    accept;
  ram_op_t op_dec;

  // strobes outside idle are simply lost
  assign accept = data_stb && idle;

  // any bit above the bank range is out of range
  always_comb begin
    if (|data_addr[ADDR_W-1:BANK_ADDR_W]) begin
      op_dec = OP_ILLEGAL;
    end else if (data_we) begin
      op_dec = OP_WRITE;
    end else begin
      op_dec = OP_READ;
    end
  end

  // request held until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      req.op       <= op_dec;
      req.addr     <= data_addr[BANK_ADDR_W-1:0];
      req.wdata_hi <= data_din[DATA_W-1:HALF_W];
      req.wdata_lo <= data_din[HALF_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= accept;
    end
  end

endmodule

/* ram_resp.sv */
//##########################################################
// response stage: merges bank halves into the held read
// word and forms the ack and timeout pulses
//##########################################################

`timescale 1ns/1ps

module ram_resp (
  input  logic                           clk,
  input  logic                           rst,
  input  ramctrl_pkg::ctrl_evt_t         evt,
  input  logic [ramctrl_pkg::HALF_W-1:0] rdata_hi,
  input  logic [ramctrl_pkg::HALF_W-1:0] rdata_lo,
  output logic [ramctrl_pkg::DATA_W-1:0] data_dout,
  output logic                           data_ack,
  output logic                           data_timeout
);

  // done states last one cycle, so these are single pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      data_ack     <= 1'b0;
      data_timeout <= 1'b0;
    end else begin
      data_ack     <= evt.done_read | evt.done_write;
      data_timeout <= evt.illegal;
    end
  end

  // both halves captured on the same edge as the ack
  always_ff @(posedge clk) begin
    if (rst) begin
      data_dout <= '0;
    end else if (evt.done_read) begin
      data_dout <= {rdata_hi, rdata_lo};
    end
  end

endmodule

/* ramctrl.f */
ramctrl_pkg.sv
ram_bank.sv
ram_req_decode.sv
ramctrl_fsm.sv
ram_resp.sv
ramctrl_top.sv
ramctrl_properties.sv
ramctrl_tb.sv

/* ramctrl_fsm.sv */
//##########################################################
// controller FSM: strobes both banks in lockstep, joins
// their acknowledges and signals completion events
//##########################################################

`timescale 1ns/1ps

module ramctrl_fsm (
  input  logic                   clk,
  input  logic                   rst,
  input  ramctrl_pkg::ram_req_t  req,
  input  logic                   req_valid,
  input  logic                   ack_hi,
  input  logic                   ack_lo,
  output ramctrl_pkg::bank_cmd_t cmd,
  output logic                   idle,
  output ramctrl_pkg::ctrl_evt_t evt
);

  import ramctrl_pkg::*;

  ctrl_state_t state;
  ctrl_state_t next_state;
  logic        both_ack;

  assign both_ack = ack_hi && ack_lo;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // a pending req_valid already counts as busy
  assign idle = (state == ST_IDLE) && !req_valid;

  always_comb begin
    next_state = state;
    cmd        = '0;
    cmd.addr   = req.addr;
    evt        = '0;
    case (state)
      ST_IDLE: begin
        if (req_valid) begin
          case (req.op)
            OP_READ:    next_state = ST_READ;
            OP_WRITE:   next_state = ST_WRITE;
            OP_ILLEGAL: next_state = ST_ILLEGAL;
            default:    next_state = ST_IDLE;
          endcase
        end
      end
      ST_READ: begin
        cmd.stb = 1'b1;
        // slower bank decides when we move on
        if (both_ack) begin
          next_state = ST_READ_DONE;
        end
      end
      ST_READ_DONE: begin
        evt.done_read = 1'b1;
        next_state    = ST_IDLE;
      end
      ST_WRITE: begin
        cmd.stb = 1'b1;
        cmd.we  = 1'b1;
        if (both_ack) begin
          next_state = ST_WRITE_DONE;
        end
      end
      ST_WRITE_DONE: begin
        evt.done_write = 1'b1;
        next_state     = ST_IDLE;
      end
      ST_ILLEGAL: begin
        // banks stay untouched
        evt.illegal = 1'b1;
        next_state  = ST_IDLE;
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

endmodule

/* ramctrl_pkg.sv */
//##########################################################
// ramctrl package: widths, bank delays, operation and state
// enums, and the request, bank command and event structs
//##########################################################

package ramctrl_pkg;

  // requester side
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;

  // bank side, two banks of half width
  localparam int BANK_ADDR_W = 10;
  localparam int BANK_DEPTH  = 1024;
  localparam int HALF_W      = 16;

  // access delays in cycles, deliberately unequal
  localparam int LAT_HI = 3;
  localparam int LAT_LO = 5;

  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE,
    OP_ILLEGAL
  } ram_op_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ,
    ST_READ_DONE,
    ST_WRITE,
    ST_WRITE_DONE,
    ST_ILLEGAL
  } ctrl_state_t;

  // latched request, high half first
  typedef struct packed {
    ram_op_t                op;
    logic [BANK_ADDR_W-1:0] addr;
    logic [HALF_W-1:0]      wdata_hi;
    logic [HALF_W-1:0]      wdata_lo;
  } ram_req_t;

  // one command, seen by both banks
  typedef struct packed {
    logic                   stb;
    logic                   we;
    logic [BANK_ADDR_W-1:0] addr;
  } bank_cmd_t;

  typedef struct packed {
    logic done_read;
    logic done_write;
    logic illegal;
  } ctrl_evt_t;

endpackage

/* ramctrl_properties.sv */
//##########################################################
// ramctrl properties: response pulse rules and bank
// command sanity, bound into the top level
//##########################################################

`timescale 1ns/1ps

module ramctrl_properties (
  input logic                     clk,
  input logic                     rst,
  input logic                     data_ack,
  input logic                     data_timeout,
  input ramctrl_pkg::bank_cmd_t   cmd,
  input ramctrl_pkg::ctrl_state_t state
);

  import ramctrl_pkg::*;

  // one kind of response at a time
  ack_timeout_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(data_ack && data_timeout))
    else $error("data_ack and data_timeout high together");

  ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
    data_ack |=> !data_ack)
    else $error("data_ack longer than one cycle");

  timeout_single_cycle: assert property (@(posedge clk) disable iff (rst)
    data_timeout |=> !data_timeout)
    else $error("data_timeout longer than one cycle");

  we_needs_stb: assert property (@(posedge clk) disable iff (rst)
    cmd.we |-> cmd.stb)
    else $error("bank write enable without strobe");

  // out of range requests leave the banks alone
  no_stb_when_illegal: assert property (@(posedge clk) disable iff (rst)
    (state == ST_ILLEGAL) |-> !cmd.stb)
    else $error("bank strobe in the illegal state");

endmodule

bind ramctrl_top ramctrl_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .data_ack     (data_ack),
  .data_timeout (data_timeout),
  .cmd          (cmd),
  .state        (u_fsm.state)
);

/* ramctrl_tb.sv */
//##########################################################
// ramctrl testbench: seeded random requests against a
// reference memory model, with latency and hold checks
//##########################################################

`timescale 1ns/1ps

module ramctrl_tb;

  import ramctrl_pkg::*;

  localparam int NUM_TXN      = 300;
  localparam int RESET_CYCLES = 16;
  localparam int ACK_LAT      = LAT_LO + 4;
  localparam int TIMEOUT_LAT  = 3;
  localparam int MAX_GAP      = 7;
  localparam int MAX_CYCLES   = RESET_CYCLES + NUM_TXN * (ACK_LAT + MAX_GAP + 10);

  logic              clk;
  logic              rst;
  logic              data_stb;
  logic              data_we;
  logic [ADDR_W-1:0] data_addr;
  logic [DATA_W-1:0] data_din;
  logic [DATA_W-1:0] data_dout;
  logic              data_ack;
  logic              data_timeout;

  // reference memory and the set of written words
  logic [DATA_W-1:0] model [logic [BANK_ADDR_W-1:0]];
  bit                written [BANK_DEPTH];
  logic [DATA_W-1:0] held_dout;
  bit                held_known;
  int                cycle_count;
  int                resp_count = 0;

  ramctrl_top DUT (
    .clk          (clk),
    .rst          (rst),
    .data_stb     (data_stb),
    .data_we      (data_we),
    .data_addr    (data_addr),
    .data_din     (data_din),
    .data_dout    (data_dout),
    .data_ack     (data_ack),
    .data_timeout (data_timeout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run length guard
  initial begin
    cycle_count = 0;
    while (cycle_count <= MAX_CYCLES) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("** Error: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TESTS FAILED");
    $fatal(1, "simulation timed out");
  end

  // response pulses seen on the outputs
  always @(negedge clk) begin
    if (data_ack || data_timeout) begin
      resp_count = resp_count + 1;
    end
  end

  task automatic report_mismatch(input string test, input logic [DATA_W-1:0] expected,
                                 input logic [DATA_W-1:0] actual);
    $display("** Error [%s] expected %h, actual %h", test, expected, actual);
    $display("TESTS FAILED");
    $fatal(1, "check %s failed", test);
  endtask

  task automatic check_value(input string test, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected) else report_mismatch(test, expected, actual);
  endtask

  // no response may show up in idle cycles
  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("single response ack", 32'h0, 32'(data_ack));
      check_value("single response timeout", 32'h0, 32'(data_timeout));
    end
  endtask

  // stray strobe while busy must be dropped
  task automatic drive_busy_strobe(input bit stray);
    if (stray) begin
      data_stb  <= 1'b1;
      data_we   <= 1'($urandom);
      data_addr <= ADDR_W'($urandom);
      data_din  <= $urandom;
    end else begin
      data_stb <= 1'b0;
    end
  endtask

  // one strobe and its response, with cycles counted from the accepting edge
  task automatic run_txn(input logic we, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] din, input int drop_at);
    logic                   illegal;
    logic [BANK_ADDR_W-1:0] ba;
    int                     exp_lat;
    int                     n;
    bit                     got;
    illegal = |addr[ADDR_W-1:BANK_ADDR_W];
    ba      = addr[BANK_ADDR_W-1:0];
    exp_lat = illegal ? TIMEOUT_LAT : ACK_LAT;
    @(posedge clk);
    data_stb  <= 1'b1;
    data_we   <= we;
    data_addr <= addr;
    data_din  <= din;
    @(posedge clk);
    n   = 0;
    got = 1'b0;
    drive_busy_strobe(n == drop_at);
    while (!got) begin
      @(negedge clk);
      n = n + 1;
      if (data_ack || data_timeout) begin
        got = 1'b1;
      end else begin
        @(posedge clk);
        drive_busy_strobe(n == drop_at);
      end
    end
    check_value("latency", exp_lat, n);
    check_value("ack kind", 32'(!illegal), 32'(data_ack));
    check_value("timeout kind", 32'(illegal), 32'(data_timeout));
    if (!illegal && !we) begin
      if (written[ba]) begin
        check_value("read data", model[ba], data_dout);
        held_dout  = model[ba];
        held_known = 1'b1;
      end else begin
        // contents of an unwritten word are unknown
        held_known = 1'b0;
      end
    end else begin
      if (!illegal) begin
        model[ba]   = din;
        written[ba] = 1'b1;
      end
      if (held_known) begin
        check_value("held data", held_dout, data_dout);
      end
    end
  endtask

  initial begin
    logic                          we;
    logic [ADDR_W-BANK_ADDR_W-1:0] top;
    logic [BANK_ADDR_W-1:0]        ba;
    logic [DATA_W-1:0]             din;
    int                            max_drop;
    int                            drop_at;
    void'($urandom(76));
    rst        = 1'b1;
    data_stb   = 1'b0;
    data_we    = 1'b0;
    data_addr  = '0;
    data_din   = '0;
    held_dout  = '0;
    held_known = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("reset ack", 32'h0, 32'(data_ack));
    check_value("reset timeout", 32'h0, 32'(data_timeout));
    check_value("reset dout", 32'h0, data_dout);
    for (int i = 0; i < NUM_TXN; i++) begin
      // small address pool so reads hit earlier writes
      if ($urandom_range(3) == 0) begin
        ba = BANK_ADDR_W'($urandom);
      end else begin
        ba = BANK_ADDR_W'($urandom_range(31));
      end
      if ($urandom_range(7) == 0) begin
        top = (ADDR_W - BANK_ADDR_W)'($urandom_range(3, 1));
      end else begin
        top = '0;
      end
      we       = 1'($urandom);
      din      = $urandom;
      max_drop = (top != '0) ? 1 : ACK_LAT - 2;
      if ($urandom_range(3) == 0) begin
        drop_at = int'($urandom_range(max_drop, 0));
      end else begin
        drop_at = -1;
      end
      run_txn(we, {top, ba}, din, drop_at);
      expect_quiet(int'($urandom_range(MAX_GAP)));
    end
    // one more cycle so the last pulse is counted
    expect_quiet(1);
    check_value("response count", NUM_TXN, resp_count);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* ramctrl_top.sv */
//##########################################################
// ramctrl top: decoder, controller FSM, two RAM banks and
// the response stage
//##########################################################

`timescale 1ns/1ps

module ramctrl_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           data_stb,
  input  logic                           data_we,
  input  logic [ramctrl_pkg::ADDR_W-1:0] data_addr,
  input  logic [ramctrl_pkg::DATA_W-1:0] data_din,
  output logic [ramctrl_pkg::DATA_W-1:0] data_dout,
  output logic                           data_ack,
  output logic                           data_timeout
);

  import ramctrl_pkg::*;

  ram_req_t          req;
  logic              req_valid;
  logic              idle;
  bank_cmd_t         cmd;
  ctrl_evt_t         evt;
  logic              ack_hi;
  logic              ack_lo;
  logic [HALF_W-1:0] rdata_hi;
  logic [HALF_W-1:0] rdata_lo;

  ram_req_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .data_stb  (data_stb),
    .data_we   (data_we),
    .data_addr (data_addr),
    .data_din  (data_din),
    .idle      (idle),
    .req       (req),
    .req_valid (req_valid)
  );

  ramctrl_fsm u_fsm (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .ack_hi    (ack_hi),
    .ack_lo    (ack_lo),
    .cmd       (cmd),
    .idle      (idle),
    .evt       (evt)
  );

  // upper half of the word
  ram_bank #(.LATENCY(LAT_HI)) u_bank_hi (
    .clk   (clk),
    .rst   (rst),
    .cmd   (cmd),
    .wdata (req.wdata_hi),
    .rdata (rdata_hi),
    .ack   (ack_hi)
  );

  // lower half of the word
  ram_bank #(.LATENCY(LAT_LO)) u_bank_lo (
    .clk   (clk),
    .rst   (rst),
    .cmd   (cmd),
    .wdata (req.wdata_lo),
    .rdata (rdata_lo),
    .ack   (ack_lo)
  );

  ram_resp u_resp (
    .clk          (clk),
    .rst          (rst),
    .evt          (evt),
    .rdata_hi     (rdata_hi),
    .rdata_lo     (rdata_lo),
    .data_dout    (data_dout),
    .data_ack     (data_ack),
    .data_timeout (data_timeout)
  );

endmodule
